// ==== hdl/cache_pkg.sv ====
package cache_pkg;

// ----------------------------------------------------------------------------
// Cache geometry.
// ----------------------------------------------------------------------------

localparam int CACHE_BYTES = 1024;
localparam int LINE_BYTES  = 16;
localparam int LINE_WORDS  = LINE_BYTES / 4;
localparam int NUM_LINES   = CACHE_BYTES / LINE_BYTES;
localparam int INDEX_W     = $clog2(NUM_LINES);
localparam int OFFSET_W    = $clog2(LINE_BYTES);
localparam int VTAG_W      = 32 - INDEX_W - OFFSET_W;
localparam int PA_LINE_W   = 32 - OFFSET_W;

// Dirty scan is done 16 lines at a time.
localparam int SCAN_GROUP  = 16;
localparam int NUM_GROUPS  = NUM_LINES / SCAN_GROUP;
localparam int WORD_W      = $clog2(LINE_WORDS);

// ----------------------------------------------------------------------------
// Types.
// ----------------------------------------------------------------------------

// Virtual tag for lookup, physical line address for write-back.
typedef struct packed {
        logic [VTAG_W-1:0]    vtag;
        logic [PA_LINE_W-1:0] pa_line;
} tag_t;

typedef logic [INDEX_W-1:0] index_t;
typedef logic [31:0]        word_t;

// Wishbone cycle type identifiers.
typedef enum logic [2:0] {
        CTI_CLASSIC = 3'b000,
        CTI_BURST   = 3'b010,
        CTI_EOB     = 3'b111
} cti_e;

// Master side outputs of the write-back port.
typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat;
        cti_e        cti;
} wb_req_t;

typedef enum logic [2:0] {
        IDLE,
        SCAN,
        READ_WAIT,
        WRITE,
        INVALIDATE
} clean_state_e;

endpackage

// ==== hdl/data_word_bank.sv ====
`timescale 1ns/1ns

module data_word_bank
        import cache_pkg::*;
(
        input  logic       i_clk,
        input  index_t     i_rd_index,
        input  index_t     i_wr_index,
        input  logic [3:0] i_ben,
        input  word_t      i_wr_word,
        output word_t      o_rd_word
);

// One 32-bit column of the line data, one word per line.
word_t mem [NUM_LINES];

// ----------------------------------------------------------------------------
// Byte-enabled write.
// ----------------------------------------------------------------------------

always_ff @ ( posedge i_clk )
begin
        for ( int b = 0; b < 4; b++ )
        begin
                if ( i_ben[b] )
                begin
                        mem[i_wr_index][8*b +: 8] <= i_wr_word[8*b +: 8];
                end
        end
end

// ----------------------------------------------------------------------------
// Registered read.
// ----------------------------------------------------------------------------

// Old contents are returned when the same word is written.
always_ff @ ( posedge i_clk )
begin
        o_rd_word <= mem[i_rd_index];
end

endmodule

// ==== hdl/line_tag_ctrl.sv ====
`timescale 1ns/1ns

module line_tag_ctrl
        import cache_pkg::*;
(
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  logic [31:0]           i_address_nxt,
        input  logic [31:0]           i_address,
        input  logic                  i_tag_wr_en,
        input  tag_t                  i_tag,
        input  logic                  i_tag_dirty,
        input  logic [LINE_BYTES-1:0] i_line_ben,
        input  logic                  i_busy,
        input  index_t                i_clean_index,
        input  logic                  i_clean_line,
        input  logic                  i_clear_valid,
        output index_t                o_rd_index,
        output index_t                o_wr_index,
        output logic [LINE_BYTES-1:0] o_bank_ben,
        output tag_t                  o_tag,
        output logic                  o_tag_valid,
        output logic                  o_tag_dirty,
        output logic [NUM_LINES-1:0]  o_dirty_vec
);

tag_t                 tag_mem [NUM_LINES];
logic [NUM_LINES-1:0] valid;
logic [NUM_LINES-1:0] dirty;
index_t               rd_index;
index_t               wr_index;
logic                 wr_accept;

// ----------------------------------------------------------------------------
// Index selection and write gating.
// ----------------------------------------------------------------------------

// The clean engine owns the read port while it runs.
always_comb
begin
        if ( i_busy )
        begin
                rd_index = i_clean_index;
        end
        else
        begin
                rd_index = i_address_nxt[OFFSET_W +: INDEX_W];
        end
end

assign wr_index   = i_address[OFFSET_W +: INDEX_W];
assign wr_accept  = i_tag_wr_en && !i_busy;
assign o_bank_ben = i_busy ? '0 : i_line_ben;

assign o_rd_index  = rd_index;
assign o_wr_index  = wr_index;
assign o_dirty_vec = dirty;

// ----------------------------------------------------------------------------
// Tag array.
// ----------------------------------------------------------------------------

always_ff @ ( posedge i_clk )
begin
        if ( wr_accept )
        begin
                tag_mem[wr_index] <= i_tag;
        end

        // Read first. A same-index write shows on the next read.
        o_tag <= tag_mem[rd_index];
end

// ----------------------------------------------------------------------------
// Valid and dirty bits.
// ----------------------------------------------------------------------------

always_ff @ ( posedge i_clk )
begin
        if ( i_reset )
        begin
                valid       <= '0;
                dirty       <= '0;
                o_tag_valid <= 1'b0;
                o_tag_dirty <= 1'b0;
        end
        else
        begin
                o_tag_valid <= valid[rd_index];
                o_tag_dirty <= dirty[rd_index];

                if ( i_clear_valid )
                begin
                        valid <= '0;
                end
                else if ( wr_accept )
                begin
                        valid[wr_index] <= 1'b1;
                end

                if ( wr_accept )
                begin
                        dirty[wr_index] <= i_tag_dirty;
                end
                else if ( i_clean_line )
                begin
                        dirty[i_clean_index] <= 1'b0;
                end
        end
end

// Write-back completion and a user fill must not race on a dirty bit.
a_clean_vs_fill: assert property (
        @( posedge i_clk ) disable iff ( i_reset )
        !( i_clean_line && wr_accept )
);

endmodule

// ==== hdl/clean_engine.sv ====
`timescale 1ns/1ns

module clean_engine
        import cache_pkg::*;
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic                    i_clean_req,
        input  logic                    i_inv_req,
        input  logic [NUM_LINES-1:0]    i_dirty_vec,
        input  tag_t                    i_tag,
        input  logic [LINE_BYTES*8-1:0] i_line,
        input  logic                    i_wb_ack,
        output logic                    o_busy,
        output index_t                  o_rd_index,
        output logic                    o_clean_line,
        output logic                    o_clear_valid,
        output logic                    o_clean_done,
        output logic                    o_inv_done,
        output wb_req_t                 o_wb
);

localparam int POS_W = $clog2(SCAN_GROUP);

clean_state_e          state_ff, state_nxt;
logic [WORD_W-1:0]     word_ff, word_nxt;
logic [WORD_W-1:0]     word_inc;
index_t                rd_index_ff, rd_index_nxt;
wb_req_t               wb_ff, wb_nxt;
logic                  clean_done_ff, clean_done_nxt;
logic [NUM_GROUPS-1:0] grp_hit;
logic [POS_W-1:0]      grp_pos [NUM_GROUPS];
logic                  scan_hit;
index_t                scan_index;

// Lowest set bit of one scan group.
function automatic logic [POS_W-1:0] first_set ( input logic [SCAN_GROUP-1:0] bits );
        logic [POS_W-1:0] pos;
        pos = '0;
        for ( int j = SCAN_GROUP - 1; j >= 0; j-- )
        begin
                if ( bits[j] )
                begin
                        pos = POS_W'(j);
                end
        end
        return pos;
endfunction

function automatic wb_req_t bus_idle ();
        wb_req_t req;
        req     = '0;
        req.cti = CTI_EOB;
        return req;
endfunction

// Word k of the line at pa*16 + 4k. Burst ends on the last word.
function automatic wb_req_t bus_write (
        input logic [PA_LINE_W-1:0]    pa,
        input logic [WORD_W-1:0]       k,
        input logic [LINE_BYTES*8-1:0] line
);
        wb_req_t req;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = 1'b1;
        req.sel = 4'b1111;
        req.adr = {pa, k, 2'b00};
        req.dat = line[k*32 +: 32];
        req.cti = ( k == WORD_W'(LINE_WORDS - 1) ) ? CTI_EOB : CTI_BURST;
        return req;
endfunction

// ----------------------------------------------------------------------------
// Dirty line scan.
// ----------------------------------------------------------------------------

always_comb
begin
        for ( int g = 0; g < NUM_GROUPS; g++ )
        begin
                grp_hit[g] = |i_dirty_vec[g*SCAN_GROUP +: SCAN_GROUP];
                grp_pos[g] = first_set(i_dirty_vec[g*SCAN_GROUP +: SCAN_GROUP]);
        end
end

// Lowest group with a hit wins.
always_comb
begin
        scan_index = '0;
        for ( int g = NUM_GROUPS - 1; g >= 0; g-- )
        begin
                if ( grp_hit[g] )
                begin
                        scan_index = index_t'(g * SCAN_GROUP) + index_t'(grp_pos[g]);
                end
        end
end

assign scan_hit = |grp_hit;
assign word_inc = word_ff + 1'b1;

// ----------------------------------------------------------------------------
// Clean and invalidate FSM.
// ----------------------------------------------------------------------------

always_comb
begin
        state_nxt      = state_ff;
        word_nxt       = word_ff;
        rd_index_nxt   = rd_index_ff;
        wb_nxt         = wb_ff;
        clean_done_nxt = 1'b0;
        o_clean_line   = 1'b0;

        case ( state_ff )
        IDLE:
        begin
                // Clean wins over invalidate.
                if ( i_clean_req && !clean_done_ff )
                begin
                        state_nxt = SCAN;
                end
                else if ( i_inv_req )
                begin
                        state_nxt = INVALIDATE;
                end
        end

        SCAN:
        begin
                word_nxt = '0;
                if ( scan_hit )
                begin
                        rd_index_nxt = scan_index;
                        state_nxt    = READ_WAIT;
                end
                else
                begin
                        clean_done_nxt = 1'b1;
                        state_nxt      = IDLE;
                end
        end

        // Tag and line come out of the arrays one cycle later.
        READ_WAIT:
        begin
                state_nxt = WRITE;
        end

        WRITE:
        begin
                if ( !wb_ff.stb )
                begin
                        wb_nxt = bus_write(i_tag.pa_line, word_ff, i_line);
                end
                else if ( i_wb_ack )
                begin
                        if ( word_ff == WORD_W'(LINE_WORDS - 1) )
                        begin
                                wb_nxt       = bus_idle();
                                o_clean_line = 1'b1;
                                state_nxt    = SCAN;
                        end
                        else
                        begin
                                word_nxt = word_inc;
                                wb_nxt   = bus_write(i_tag.pa_line, word_inc, i_line);
                        end
                end
        end

        INVALIDATE:
        begin
                state_nxt = IDLE;
        end

        default:
        begin
                state_nxt = IDLE;
        end
        endcase
end

always_ff @ ( posedge i_clk )
begin
        if ( i_reset )
        begin
                state_ff      <= IDLE;
                word_ff       <= '0;
                rd_index_ff   <= '0;
                wb_ff         <= bus_idle();
                clean_done_ff <= 1'b0;
        end
        else
        begin
                state_ff      <= state_nxt;
                word_ff       <= word_nxt;
                rd_index_ff   <= rd_index_nxt;
                wb_ff         <= wb_nxt;
                clean_done_ff <= clean_done_nxt;
        end
end

assign o_busy        = ( state_ff != IDLE );
assign o_rd_index    = rd_index_ff;
assign o_clear_valid = ( state_ff == INVALIDATE );
assign o_inv_done    = ( state_ff == INVALIDATE );
assign o_clean_done  = clean_done_ff;
assign o_wb          = wb_ff;

// ----------------------------------------------------------------------------
// Bus protocol checks.
// ----------------------------------------------------------------------------

a_stb_in_cyc: assert property (
        @( posedge i_clk ) disable iff ( i_reset )
        wb_ff.stb |-> wb_ff.cyc
);

// A stalled transfer holds everything until the slave acks.
a_stall_hold: assert property (
        @( posedge i_clk ) disable iff ( i_reset )
        ( wb_ff.stb && !i_wb_ack ) |=> $stable(wb_ff)
);

endmodule

// ==== hdl/cache_line_store.sv ====
`timescale 1ns/1ns

module cache_line_store
        import cache_pkg::*;
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic [31:0]             i_address_nxt,
        input  logic [31:0]             i_address,
        input  logic                    i_tag_wr_en,
        input  tag_t                    i_tag,
        input  logic                    i_tag_dirty,
        input  logic [LINE_BYTES*8-1:0] i_line,
        input  logic [LINE_BYTES-1:0]   i_line_ben,
        input  logic                    i_clean_req,
        input  logic                    i_inv_req,
        input  logic                    i_wb_ack,
        output tag_t                    o_tag,
        output logic                    o_tag_valid,
        output logic                    o_tag_dirty,
        output logic [LINE_BYTES*8-1:0] o_line,
        output logic                    o_clean_done,
        output logic                    o_inv_done,
        output wb_req_t                 o_wb
);

index_t                  rd_index;
index_t                  wr_index;
index_t                  clean_index;
logic [LINE_BYTES-1:0]   bank_ben;
logic [NUM_LINES-1:0]    dirty_vec;
logic                    busy;
logic                    clean_line;
logic                    clear_valid;
word_t                   bank_word [LINE_WORDS];
logic [LINE_BYTES*8-1:0] line_rd;

line_tag_ctrl u_ctrl (
        .i_clk          ( i_clk ),
        .i_reset        ( i_reset ),
        .i_address_nxt  ( i_address_nxt ),
        .i_address      ( i_address ),
        .i_tag_wr_en    ( i_tag_wr_en ),
        .i_tag          ( i_tag ),
        .i_tag_dirty    ( i_tag_dirty ),
        .i_line_ben     ( i_line_ben ),
        .i_busy         ( busy ),
        .i_clean_index  ( clean_index ),
        .i_clean_line   ( clean_line ),
        .i_clear_valid  ( clear_valid ),
        .o_rd_index     ( rd_index ),
        .o_wr_index     ( wr_index ),
        .o_bank_ben     ( bank_ben ),
        .o_tag          ( o_tag ),
        .o_tag_valid    ( o_tag_valid ),
        .o_tag_dirty    ( o_tag_dirty ),
        .o_dirty_vec    ( dirty_vec )
);

// One bank per 32-bit word of the line.
for ( genvar w = 0; w < LINE_WORDS; w++ )
begin : g_bank
        data_word_bank u_bank (
                .i_clk      ( i_clk ),
                .i_rd_index ( rd_index ),
                .i_wr_index ( wr_index ),
                .i_ben      ( bank_ben[4*w +: 4] ),
                .i_wr_word  ( i_line[32*w +: 32] ),
                .o_rd_word  ( bank_word[w] )
        );
end

always_comb
begin
        for ( int w = 0; w < LINE_WORDS; w++ )
        begin
                line_rd[32*w +: 32] = bank_word[w];
        end
end

assign o_line = line_rd;

clean_engine u_clean (
        .i_clk          ( i_clk ),
        .i_reset        ( i_reset ),
        .i_clean_req    ( i_clean_req ),
        .i_inv_req      ( i_inv_req ),
        .i_dirty_vec    ( dirty_vec ),
        .i_tag          ( o_tag ),
        .i_line         ( line_rd ),
        .i_wb_ack       ( i_wb_ack ),
        .o_busy         ( busy ),
        .o_rd_index     ( clean_index ),
        .o_clean_line   ( clean_line ),
        .o_clear_valid  ( clear_valid ),
        .o_clean_done   ( o_clean_done ),
        .o_inv_done     ( o_inv_done ),
        .o_wb           ( o_wb )
);

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen
#(
        parameter int PERIOD       = 20,
        parameter int RESET_CYCLES = 2
)
(
        output logic o_clk,
        output logic o_reset
);

initial
begin
        o_clk = 1'b0;
        forever
        begin
                #(PERIOD / 2);
                o_clk = ~o_clk;
        end
end

// Reset spans the first rising edges and drops on a falling edge.
initial
begin
        o_reset = 1'b1;
        repeat ( RESET_CYCLES ) @( posedge o_clk );
        @( negedge o_clk );
        o_reset = 1'b0;
end

endmodule

// ==== verif/wb_slave_model.sv ====
`timescale 1ns/1ns

module wb_slave_model
        import cache_pkg::*;
(
        input  logic    i_clk,
        input  wb_req_t i_wb,
        output logic    o_ack
);

localparam int LOG_DEPTH = 256;

// Every accepted write, in bus order.
logic [31:0] log_adr [LOG_DEPTH];
logic [31:0] log_dat [LOG_DEPTH];
logic [2:0]  log_cti [LOG_DEPTH];
logic [3:0]  log_sel [LOG_DEPTH];
int          log_count;
integer      seed;
int          delay;

initial
begin
        seed      = 19121;
        o_ack     = 1'b0;
        log_count = 0;
        delay     = $unsigned($random(seed)) % 4;
end

// Ack is raised on a falling edge and seen by the master at the next rising edge.
always @ ( negedge i_clk )
begin
        if ( o_ack )
        begin
                o_ack = 1'b0;
                delay = $unsigned($random(seed)) % 4;
        end
        else if ( i_wb.cyc && i_wb.stb && i_wb.we )
        begin
                if ( delay == 0 )
                begin
                        o_ack              = 1'b1;
                        log_adr[log_count] = i_wb.adr;
                        log_dat[log_count] = i_wb.dat;
                        log_cti[log_count] = i_wb.cti;
                        log_sel[log_count] = i_wb.sel;
                        log_count++;
                end
                else
                begin
                        delay--;
                end
        end
end

endmodule

// ==== verif/cache_line_store_tb.sv ====
`timescale 1ns/1ns

module cache_line_store_tb
        import cache_pkg::*;
();

typedef enum logic [2:0] {
        OP_FILL,
        OP_LOOKUP,
        OP_CHECK_ALL,
        OP_CLEAN,
        OP_INVALIDATE
} op_e;

typedef struct packed {
        op_e                     op;
        index_t                  index;
        tag_t                    tag;
        logic                    dirty;
        logic [LINE_BYTES*8-1:0] line;
        logic [LINE_BYTES-1:0]   ben;
} stim_t;

localparam int CLK_PERIOD  = 20;
localparam int NUM_ROWS    = 21;
localparam int WAIT_LIMIT  = NUM_LINES * (LINE_WORDS * 4 + 4) + 10;
localparam int WATCHDOG_NS = NUM_ROWS * WAIT_LIMIT * CLK_PERIOD;

logic                    clk;
logic                    reset;
logic [31:0]             address_nxt;
logic [31:0]             address;
logic                    tag_wr_en;
tag_t                    tag_in;
logic                    tag_dirty;
logic [LINE_BYTES*8-1:0] line_in;
logic [LINE_BYTES-1:0]   line_ben;
logic                    clean_req;
logic                    inv_req;
logic                    wb_ack;
tag_t                    tag_out;
logic                    tag_valid;
logic                    tag_dirty_out;
logic [LINE_BYTES*8-1:0] line_out;
logic                    clean_done;
logic                    inv_done;
wb_req_t                 wb;

// Reference model of the line store.
tag_t                    model_tag  [NUM_LINES];
logic [LINE_BYTES*8-1:0] model_line [NUM_LINES];
logic [NUM_LINES-1:0]    model_valid;
logic [NUM_LINES-1:0]    model_dirty;
logic [NUM_LINES-1:0]    model_filled;
stim_t                   rows [NUM_ROWS];

tb_clock_gen #( .PERIOD ( CLK_PERIOD ), .RESET_CYCLES ( 2 ) ) clk_gen_i (
        .o_clk   ( clk ),
        .o_reset ( reset )
);

cache_line_store dut_i (
        .i_clk         ( clk ),
        .i_reset       ( reset ),
        .i_address_nxt ( address_nxt ),
        .i_address     ( address ),
        .i_tag_wr_en   ( tag_wr_en ),
        .i_tag         ( tag_in ),
        .i_tag_dirty   ( tag_dirty ),
        .i_line        ( line_in ),
        .i_line_ben    ( line_ben ),
        .i_clean_req   ( clean_req ),
        .i_inv_req     ( inv_req ),
        .i_wb_ack      ( wb_ack ),
        .o_tag         ( tag_out ),
        .o_tag_valid   ( tag_valid ),
        .o_tag_dirty   ( tag_dirty_out ),
        .o_line        ( line_out ),
        .o_clean_done  ( clean_done ),
        .o_inv_done    ( inv_done ),
        .o_wb          ( wb )
);

wb_slave_model slave_i (
        .i_clk ( clk ),
        .i_wb  ( wb ),
        .o_ack ( wb_ack )
);

// ----------------------------------------------------------------------------
// Checking helpers.
// ----------------------------------------------------------------------------

task automatic fail_run ( input string why );
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "Stopped at the first error.");
endtask

task automatic check_value ( input string name, input logic [127:0] got,
                             input logic [127:0] exp );
        assert ( got === exp )
        else fail_run($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
endtask

function automatic stim_t make_row ( input op_e op, input index_t index,
                                     input logic [VTAG_W-1:0] vtag,
                                     input logic [PA_LINE_W-1:0] pa, input logic dirty,
                                     input logic [127:0] line, input logic [15:0] ben );
        stim_t row;
        row.op          = op;
        row.index       = index;
        row.tag.vtag    = vtag;
        row.tag.pa_line = pa;
        row.dirty       = dirty;
        row.line        = line;
        row.ben         = ben;
        return row;
endfunction

// ----------------------------------------------------------------------------
// Operations. Each starts and ends on a falling edge.
// ----------------------------------------------------------------------------

task automatic apply_fill ( input stim_t row );
        address   = {row.tag.vtag, row.index, 4'h0};
        tag_wr_en = 1'b1;
        tag_in    = row.tag;
        tag_dirty = row.dirty;
        line_in   = row.line;
        line_ben  = row.ben;
        @( negedge clk );
        tag_wr_en = 1'b0;
        line_ben  = '0;

        model_tag[row.index]    = row.tag;
        model_valid[row.index]  = 1'b1;
        model_dirty[row.index]  = row.dirty;
        model_filled[row.index] = 1'b1;
        for ( int b = 0; b < LINE_BYTES; b++ )
        begin
                if ( row.ben[b] )
                begin
                        model_line[row.index][8*b +: 8] = row.line[8*b +: 8];
                end
        end
endtask

task automatic check_lookup ( input index_t idx );
        address_nxt = {22'd0, idx, 4'h0};
        @( negedge clk );
        check_value($sformatf("o_tag_valid[%0d]", idx), tag_valid, model_valid[idx]);
        check_value($sformatf("o_tag_dirty[%0d]", idx), tag_dirty_out, model_dirty[idx]);
        if ( model_filled[idx] )
        begin
                check_value($sformatf("o_tag[%0d]", idx), tag_out, model_tag[idx]);
                check_value($sformatf("o_line[%0d]", idx), line_out, model_line[idx]);
        end
endtask

task automatic run_clean ();
        int cycles;
        int n;
        logic [31:0] exp_adr;
        n         = slave_i.log_count;
        cycles    = 0;
        clean_req = 1'b1;
        @( negedge clk );
        while ( !clean_done )
        begin
                cycles++;
                if ( cycles > WAIT_LIMIT )
                begin
                        fail_run("Timed out waiting for the clean to finish.");
                end
                @( negedge clk );
        end
        clean_req = 1'b0;
        check_value("o_wb.cyc", wb.cyc, 1'b0);
        check_value("o_wb.stb", wb.stb, 1'b0);
        @( negedge clk );
        check_value("o_clean_done", clean_done, 1'b0);

        // Dirty lines go out lowest index first, four words each.
        for ( int idx = 0; idx < NUM_LINES; idx++ )
        begin
                if ( model_dirty[idx] )
                begin
                        for ( int k = 0; k < LINE_WORDS; k++ )
                        begin
                                assert ( n < slave_i.log_count )
                                else fail_run("The clean wrote fewer words than expected.");
                                exp_adr = (32'(model_tag[idx].pa_line) << 4) + 32'(4 * k);
                                check_value("wb adr", slave_i.log_adr[n], exp_adr);
                                check_value("wb dat", slave_i.log_dat[n],
                                            model_line[idx][32*k +: 32]);
                                check_value("wb cti", slave_i.log_cti[n],
                                            ( k == LINE_WORDS - 1 ) ? CTI_EOB : CTI_BURST);
                                check_value("wb sel", slave_i.log_sel[n], 4'hf);
                                n++;
                        end
                end
        end
        check_value("wb write count", slave_i.log_count, n);
        model_dirty = '0;
endtask

task automatic run_invalidate ();
        int cycles;
        cycles  = 0;
        inv_req = 1'b1;
        @( negedge clk );
        while ( !inv_done )
        begin
                cycles++;
                if ( cycles > WAIT_LIMIT )
                begin
                        fail_run("Timed out waiting for the invalidate to finish.");
                end
                @( negedge clk );
        end
        inv_req = 1'b0;
        // Valid bits clear at the end of the done cycle.
        @( negedge clk );
        check_value("o_inv_done", inv_done, 1'b0);
        model_valid = '0;
endtask

// ----------------------------------------------------------------------------
// Stimulus table.
// ----------------------------------------------------------------------------

task automatic load_table ();
        rows[0]  = make_row(OP_CHECK_ALL, 6'd0, 22'h0, 28'h0, 1'b0, '0, 16'h0);
        rows[1]  = make_row(OP_FILL, 6'd3, 22'h1A2B3, 28'h8000123, 1'b1,
                            128'h0F0E0D0C_0B0A0908_07060504_03020100, 16'hffff);
        rows[2]  = make_row(OP_LOOKUP, 6'd3, 22'h0, 28'h0, 1'b0, '0, 16'h0);
        rows[3]  = make_row(OP_FILL, 6'd3, 22'h1A2B3, 28'h8000123, 1'b1,
                            128'hA5A5A5A5_5A5A5A5A_C3C3C3C3_3C3C3C3C, 16'h0f3c);
        rows[4]  = make_row(OP_LOOKUP, 6'd3, 22'h0, 28'h0, 1'b0, '0, 16'h0);
        rows[5]  = make_row(OP_FILL, 6'd17, 22'h00444, 28'h0123456, 1'b1,
                            128'hDEADBEEF_CAFEF00D_12345678_9ABCDEF0, 16'hffff);
        rows[6]  = make_row(OP_FILL, 6'd40, 22'h3FFFF, 28'h7654321, 1'b0,
                            128'h01234567_89ABCDEF_FEDCBA98_76543210, 16'hffff);
        rows[7]  = make_row(OP_FILL, 6'd62, 22'h2AAAA, 28'hFFFFFF0, 1'b1,
                            128'h11112222_33334444_55556666_77778888, 16'hffff);
        rows[8]  = make_row(OP_FILL, 6'd0, 22'h15555, 28'h0000010, 1'b0,
                            128'h90909090_80808080_70707070_60606060, 16'hffff);
        rows[9]  = make_row(OP_LOOKUP, 6'd40, 22'h0, 28'h0, 1'b0, '0, 16'h0);
        rows[10] = make_row(OP_CLEAN, 6'd0, 22'h0, 28'h0, 1'b0, '0, 16'h0);
        rows[11] = make_row(OP_CHECK_ALL, 6'd0, 22'h0, 28'h0, 1'b0, '0, 16'h0);
        // Nothing is dirty here, so no bus writes.
        rows[12] = make_row(OP_CLEAN, 6'd0, 22'h0, 28'h0, 1'b0, '0, 16'h0);
        rows[13] = make_row(OP_FILL, 6'd5, 22'h00005, 28'h0ABCDEF, 1'b1,
                            128'h55555555_66666666_77777777_88888888, 16'hffff);
        rows[14] = make_row(OP_INVALIDATE, 6'd0, 22'h0, 28'h0, 1'b0, '0, 16'h0);
        rows[15] = make_row(OP_CHECK_ALL, 6'd0, 22'h0, 28'h0, 1'b0, '0, 16'h0);
        rows[16] = make_row(OP_FILL, 6'd40, 22'h3FFFF, 28'h7654321, 1'b1,
                            128'hEEEEEEEE_DDDDDDDD_CCCCCCCC_BBBBBBBB, 16'hf0f0);
        rows[17] = make_row(OP_LOOKUP, 6'd40, 22'h0, 28'h0, 1'b0, '0, 16'h0);
        rows[18] = make_row(OP_CHECK_ALL, 6'd0, 22'h0, 28'h0, 1'b0, '0, 16'h0);
        // Line 5 is invalid but still dirty, so it is written back too.
        rows[19] = make_row(OP_CLEAN, 6'd0, 22'h0, 28'h0, 1'b0, '0, 16'h0);
        rows[20] = make_row(OP_CHECK_ALL, 6'd0, 22'h0, 28'h0, 1'b0, '0, 16'h0);
endtask

// ----------------------------------------------------------------------------
// Main sequence and watchdog.
// ----------------------------------------------------------------------------

initial
begin
        address_nxt  = '0;
        address      = '0;
        tag_wr_en    = 1'b0;
        tag_in       = '0;
        tag_dirty    = 1'b0;
        line_in      = '0;
        line_ben     = '0;
        clean_req    = 1'b0;
        inv_req      = 1'b0;
        model_valid  = '0;
        model_dirty  = '0;
        model_filled = '0;
        load_table();

        wait ( !reset );
        @( negedge clk );
        check_value("o_wb.cyc", wb.cyc, 1'b0);
        check_value("o_wb.stb", wb.stb, 1'b0);

        for ( int r = 0; r < NUM_ROWS; r++ )
        begin
                case ( rows[r].op )
                OP_FILL:       apply_fill(rows[r]);
                OP_LOOKUP:     check_lookup(rows[r].index);
                OP_CLEAN:      run_clean();
                OP_INVALIDATE: run_invalidate();
                default:
                begin
                        for ( int i = 0; i < NUM_LINES; i++ )
                        begin
                                check_lookup(index_t'(i));
                        end
                end
                endcase
        end

        $display("Test completed successfully");
        $finish;
end

initial
begin
        #(WATCHDOG_NS);
        fail_run("Test timed out before all table rows were applied.");
end

endmodule

// ==== cache_line_store.f ====
hdl/cache_pkg.sv
hdl/data_word_bank.sv
hdl/line_tag_ctrl.sv
hdl/clean_engine.sv
hdl/cache_line_store.sv
verif/tb_clock_gen.sv
verif/wb_slave_model.sv
verif/cache_line_store_tb.sv
